/* interp_consts.svh */
`ifndef INTERP_CONSTS_SVH
`define INTERP_CONSTS_SVH

// --------------------
// Sample and row sizes
// --------------------
`define SAMPLE_W 8
`define OUT_W 16
`define IN_LEN 11
`define OUT_LEN 21

// Least number of cycles from one row strobe to the next.
`define MIN_GAP 4

// --------------------
// Register block
// --------------------
`define REG_W 16
`define CTRL_ENABLE_BIT 0
`define CTRL_FLUSH_BIT 1

`endif

/* interp_data_pkg.sv */
`default_nettype none

`include "interp_consts.svh"

package interp_data_pkg;

   // Signed samples on either side of the core.
   typedef logic signed [`SAMPLE_W-1:0] sample_t;
   typedef logic signed [`OUT_W-1:0]    out_sample_t;

   // --------------------
   // Rows
   // --------------------

   // Element 0 holds the first sample received.
   typedef struct packed {
      sample_t [`IN_LEN-1:0] smp;
   } in_row_t;

   // Even elements carry the input samples and odd elements the interpolated ones.
   typedef struct packed {
      out_sample_t [`OUT_LEN-1:0] smp;
   } out_row_t;

endpackage

`default_nettype wire

/* interp_reg_pkg.sv */
`default_nettype none

`include "interp_consts.svh"

package interp_reg_pkg;

   typedef logic [`REG_W-1:0] reg_data_t;

   typedef enum logic [1:0] {
      CTRL     = 2'd0,   // Enable in bit 0, flush command in bit 1.
      ROWS_IN  = 2'd1,
      ROWS_OUT = 2'd2
   } reg_addr_t;

   // --------------------
   // Side-band structs
   // --------------------

   // Register block to datapath. Flush is a one-cycle pulse.
   typedef struct packed {
      logic enable;
      logic flush;
   } interp_cfg_t;

   // Datapath to register block, one pulse per event.
   typedef struct packed {
      logic row_in;    // A full row has been assembled.
      logic row_out;   // The core presented a result row.
   } interp_ev_t;

endpackage

`default_nettype wire

/* row_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interp_consts.svh"

module row_assembler (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire interp_data_pkg::sample_t     sample,
   input  wire                               sample_valid,
   input  wire interp_reg_pkg::interp_cfg_t  cfg,
   output interp_data_pkg::in_row_t          row,
   output logic                              row_strobe,
   output logic                              row_in
);
   import interp_data_pkg::*;

   localparam int IDX_W = $clog2(`IN_LEN);
   localparam int GAP_W = $clog2(`MIN_GAP);
   localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(`IN_LEN - 1);
   localparam logic [IDX_W-1:0] FLUSH_MAX = IDX_W'(`IN_LEN - 1 - `MIN_GAP);
   localparam logic [GAP_W-1:0] GAP_MAX   = GAP_W'(`MIN_GAP - 1);

   in_row_t          stage;
   in_row_t          stage_next;
   logic [IDX_W-1:0] fill_idx;     // Samples held in the staging row.
   logic [GAP_W-1:0] gap_cnt;      // Cycles since the last strobe, saturating.
   logic             flush_pend;
   logic             have_row;
   logic             accept;
   logic             row_done;
   logic             flush_req;
   logic             flush_go;

   assign accept    = sample_valid & cfg.enable;
   assign row_done  = accept && (fill_idx == LAST_IDX);
   assign flush_req = (flush_pend | cfg.flush) & have_row;   // No row yet means nothing to drain.

   // A flush must also keep clear of a row that could finish inside the gap.
   // When the staging row is that far along, the flush merges into its strobe.
   assign flush_go = flush_req & ~row_done & (gap_cnt == GAP_MAX) & (fill_idx <= FLUSH_MAX);

   // Newest sample enters at the top, so the first one ends up in element 0.
   always_comb
   begin
      stage_next.smp = {sample, stage.smp[`IN_LEN-1:1]};
   end

   // --------------------
   // Control
   // --------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fill_idx   <= '0;
         gap_cnt    <= GAP_MAX;   // The first strobe may go at once.
         flush_pend <= 1'b0;
         have_row   <= 1'b0;
         row_strobe <= 1'b0;
         row_in     <= 1'b0;
      end
      else
      begin
         if (accept)
            fill_idx <= row_done ? '0 : fill_idx + 1'b1;

         if (row_done || flush_go)
            gap_cnt <= '0;
         else if (gap_cnt != GAP_MAX)
            gap_cnt <= gap_cnt + 1'b1;

         flush_pend <= flush_req & ~row_done & ~flush_go;
         if (row_done)
            have_row <= 1'b1;

         row_strobe <= row_done | flush_go;
         row_in     <= row_done;
      end
   end

   // Payload.
   always_ff @(posedge clk)
   begin
      if (accept)
         stage <= stage_next;
      if (row_done)
         row <= stage_next;   // Held until the next full row.
   end

endmodule

`default_nettype wire

/* row_interp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interp_consts.svh"

module row_interp (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire interp_data_pkg::in_row_t  row,
   input  wire                            row_strobe,
   output interp_data_pkg::out_row_t      out_row,
   output logic                           out_valid
);
   import interp_data_pkg::*;

   localparam int NODD  = `IN_LEN - 1;    // Interpolated samples per row.
   localparam int RES_W = `SAMPLE_W + 1;

   in_row_t                 x_q;
   sample_t                 ta_q  [NODD];
   sample_t                 tb_q  [NODD];
   sample_t                 tc_q  [NODD];
   logic signed [RES_W-1:0] sum_q [NODD];
   sample_t                 sub_q [NODD];
   logic signed [RES_W-1:0] res_q [`OUT_LEN];
   logic                    primed;

   // Kernel weights 3/8, 3/4 and -1/8 as shift pairs.
   function automatic sample_t quarter_eighth(input sample_t v);
      return (v >>> 2) + (v >>> 3);
   endfunction

   function automatic sample_t half_quarter(input sample_t v);
      return (v >>> 1) + (v >>> 2);
   endfunction

   function automatic sample_t eighth(input sample_t v);
      return v >>> 3;
   endfunction

   // --------------------
   // Strobed registers
   // --------------------
   always_ff @(posedge clk)
   begin
      if (row_strobe)
      begin
         x_q <= row;
         for (int i = 0; i < `OUT_LEN; i++)
            out_row.smp[i] <= out_sample_t'(res_q[i]);   // Sign extension to 16 bits.
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         primed    <= 1'b0;
         out_valid <= 1'b0;
      end
      else
      begin
         out_valid <= row_strobe & primed;
         if (row_strobe)
            primed <= 1'b1;
      end
   end

   // --------------------
   // Pipeline
   // --------------------

   // Stage 1 splits each odd output into two added terms and one subtracted term.
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < NODD - 1; k++)
      begin
         ta_q[k] <= quarter_eighth(x_q.smp[k]);
         tb_q[k] <= half_quarter(x_q.smp[k+1]);
         tc_q[k] <= eighth(x_q.smp[k+2]);
      end
      // The last odd sample has no right neighbour, so the kernel is mirrored.
      ta_q[NODD-1] <= quarter_eighth(x_q.smp[NODD]);
      tb_q[NODD-1] <= half_quarter(x_q.smp[NODD-1]);
      tc_q[NODD-1] <= eighth(x_q.smp[NODD-2]);
   end

   // Stage 2.
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < NODD; k++)
      begin
         sum_q[k] <= ta_q[k] + tb_q[k];
         sub_q[k] <= tc_q[k];
      end
   end

   // Stage 3 holds all 21 results at nine bits.
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < `IN_LEN; k++)
         res_q[2*k] <= sample_t'(x_q.smp[k]);
      for (int k = 0; k < NODD; k++)
         res_q[2*k+1] <= sum_q[k] - sub_q[k];
   end

endmodule

`default_nettype wire

/* interp_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interp_consts.svh"

module interp_regs (
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire                              reg_wr,
   input  wire interp_reg_pkg::reg_addr_t   reg_addr,
   input  wire interp_reg_pkg::reg_data_t   reg_wdata,
   output interp_reg_pkg::reg_data_t        reg_rdata,
   input  wire interp_reg_pkg::interp_ev_t  ev,
   output interp_reg_pkg::interp_cfg_t      cfg
);
   import interp_reg_pkg::*;

   logic      enable_q;
   logic      flush_q;
   reg_data_t rows_in_q;
   reg_data_t rows_out_q;
   logic      ctrl_wr;

   assign ctrl_wr = reg_wr && (reg_addr == CTRL);

   assign cfg = '{enable: enable_q, flush: flush_q};

   // --------------------
   // Control register
   // --------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         enable_q <= 1'b0;
         flush_q  <= 1'b0;
      end
      else
      begin
         if (ctrl_wr)
            enable_q <= reg_wdata[`CTRL_ENABLE_BIT];
         flush_q <= ctrl_wr & reg_wdata[`CTRL_FLUSH_BIT];   // Self-clearing.
      end
   end

   // Row counters wrap and are read only.
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rows_in_q  <= '0;
         rows_out_q <= '0;
      end
      else
      begin
         if (ev.row_in)
            rows_in_q <= rows_in_q + 1'b1;
         if (ev.row_out)
            rows_out_q <= rows_out_q + 1'b1;
      end
   end

   // --------------------
   // Read mux
   // --------------------
   always_comb
   begin
      reg_rdata = '0;
      case (reg_addr)
         CTRL:     reg_rdata[`CTRL_ENABLE_BIT] = enable_q;   // Flush always reads as 0.
         ROWS_IN:  reg_rdata = rows_in_q;
         ROWS_OUT: reg_rdata = rows_out_q;
         default:  reg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* interp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module interp_top (
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire interp_data_pkg::sample_t   sample,
   input  wire                             sample_valid,
   input  wire                             reg_wr,
   input  wire interp_reg_pkg::reg_addr_t  reg_addr,
   input  wire interp_reg_pkg::reg_data_t  reg_wdata,
   output interp_reg_pkg::reg_data_t       reg_rdata,
   output interp_data_pkg::out_row_t       out_row,
   output logic                            out_valid
);
   import interp_data_pkg::*;
   import interp_reg_pkg::*;

   wire interp_cfg_t cfg;
   wire in_row_t     row;
   wire              row_strobe;
   wire              row_in;

   // Events gathered from both halves of the datapath.
   wire interp_ev_t  ev = '{row_in: row_in, row_out: out_valid};

   // --------------------
   // Datapath
   // --------------------
   row_assembler u_asm (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample       (sample),
      .sample_valid (sample_valid),
      .cfg          (cfg),
      .row          (row),
      .row_strobe   (row_strobe),
      .row_in       (row_in)
   );

   row_interp u_interp (
      .clk        (clk),
      .rst_n      (rst_n),
      .row        (row),
      .row_strobe (row_strobe),
      .out_row    (out_row),
      .out_valid  (out_valid)
   );

   // Register block beside the datapath.
   interp_regs u_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .reg_wr    (reg_wr),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .ev        (ev),
      .cfg       (cfg)
   );

endmodule

`default_nettype wire

/* interp_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interp_consts.svh"

module interp_chk (
   input wire clk,
   input wire rst_n,
   input wire row_strobe,
   input wire out_valid
);

   int   fail_cnt = 0;
   int   since_strobe;   // Saturates at the minimum gap.
   logic strobe_seen;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         since_strobe <= `MIN_GAP;
         strobe_seen  <= 1'b0;
      end
      else
      begin
         if (row_strobe)
            since_strobe <= 1;
         else if (since_strobe < `MIN_GAP)
            since_strobe <= since_strobe + 1;
         if (row_strobe)
            strobe_seen <= 1'b1;
      end
   end

   // --------------------
   strobe_gap: assert property (@(posedge clk) disable iff (!rst_n)
      row_strobe |-> since_strobe >= `MIN_GAP)
   else
   begin
      fail_cnt++;
      $error("Row strobes closer than the minimum gap.");
   end

   valid_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(row_strobe))
   else
   begin
      fail_cnt++;
      $error("out_valid without a strobe on the cycle before.");
   end

   // The first strobe only fills the pipeline.
   first_strobe_silent: assert property (@(posedge clk) disable iff (!rst_n)
      row_strobe && !strobe_seen |=> !out_valid)
   else
   begin
      fail_cnt++;
      $error("out_valid after the first strobe since reset.");
   end

endmodule

`default_nettype wire

/* tb_interp_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interp_consts.svh"

module tb_interp_top;
   import interp_data_pkg::*;
   import interp_reg_pkg::*;

   localparam int N_TAB       = 6;
   localparam int N_RAND      = 20;
   localparam int MAX_GAP     = 8;   // Most idle cycles after any row.
   localparam int FLUSH_AFTER = 2;
   localparam int CYCLE_LIMIT = (N_TAB + N_RAND) * (`IN_LEN + MAX_GAP + `MIN_GAP) + 200;

   logic      clk = 1'b0;
   logic      rst_n;
   sample_t   sample;
   logic      sample_valid;
   logic      reg_wr;
   reg_addr_t reg_addr;
   reg_data_t reg_wdata;
   reg_data_t reg_rdata;
   out_row_t  out_row;
   logic      out_valid;

   logic [31:0] lfsr_state = 32'h3f54df71;
   out_row_t    exp_q [$];
   string       name_q [$];
   out_row_t    latched;              // Row result the core holds for its next strobe.
   string       latched_name;
   logic        have_latched = 1'b0;
   logic        strobe_banned = 1'b0;
   int          outs_exp = 0;
   int          outs_seen = 0;
   int          rows_sent = 0;
   int          cycles = 0;

   // --------------------
   // Hand-checked rows of zeros, 127, -128, alternating values, a ramp and an impulse.
   int tab_in [N_TAB][`IN_LEN] = '{
      '{default: 0},
      '{default: 127},
      '{default: -128},
      '{127, -128, 127, -128, 127, -128, 127, -128, 127, -128, 127},
      '{-50, -40, -30, -20, -10, 0, 10, 20, 30, 40, 50},
      '{0, 0, 0, 0, 0, 100, 0, 0, 0, 0, 0}
   };
   int tab_gap [N_TAB] = '{3, 0, 0, 5, 1, 2};
   int tab_exp [N_TAB][`OUT_LEN] = '{
      '{default: 0},
      '{127, 125, 127, 125, 127, 125, 127, 125, 127, 125, 127,
        125, 127, 125, 127, 125, 127, 125, 127, 125, 127},
      '{default: -128},
      '{127, -65, -128, 62, 127, -65, -128, 62, 127, -65, -128,
        62, 127, -65, -128, 62, 127, -65, -128, -65, 127},
      '{-50, -46, -40, -35, -30, -25, -20, -16, -10, -6, 0,
        5, 10, 15, 20, 24, 30, 34, 40, 45, 50},
      '{0, 0, 0, 0, 0, 0, 0, -12, 0, 75, 100,
        37, 0, 0, 0, 0, 0, 0, 0, 0, 0}
   };

   interp_top DUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample       (sample),
      .sample_valid (sample_valid),
      .reg_wr       (reg_wr),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_rdata    (reg_rdata),
      .out_row      (out_row),
      .out_valid    (out_valid)
   );

   bind row_interp interp_chk u_chk (
      .clk        (clk),
      .rst_n      (rst_n),
      .row_strobe (row_strobe),
      .out_valid  (out_valid)
   );

   always #2 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "Run stopped at the first error.");
   endtask

   task automatic check_val(input string name, input logic [$bits(out_row_t)-1:0] expv, actv);
      if (expv !== actv)
      begin
         $display("MISMATCH %s expected %0h actual %0h", name, expv, actv);
         abort_run("A compared value was wrong.");
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1 that steps once for each bit taken.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic int fdiv(input int v, input int d);
      if (v >= 0)
         return v / d;
      return -((-v + d - 1) / d);   // Rounds toward minus infinity.
   endfunction

   // Output rule of the interpolator, computed in plain integers.
   function automatic out_row_t ref_row(input in_row_t r);
      int       x [`IN_LEN];
      int       y;
      out_row_t o;
      for (int k = 0; k < `IN_LEN; k++)
      begin
         x[k] = r.smp[k];
         o.smp[2*k] = out_sample_t'(x[k]);
      end
      for (int k = 0; k < `IN_LEN - 2; k++)
      begin
         y = fdiv(x[k], 4) + fdiv(x[k], 8) + fdiv(x[k+1], 2) + fdiv(x[k+1], 4)
             - fdiv(x[k+2], 8);
         o.smp[2*k+1] = out_sample_t'(y);
      end
      y = fdiv(x[9], 2) + fdiv(x[9], 4) + fdiv(x[10], 4) + fdiv(x[10], 8) - fdiv(x[8], 8);
      o.smp[19] = out_sample_t'(y);
      return o;
   endfunction

   function automatic in_row_t tab_row(input int t);
      in_row_t r;
      for (int i = 0; i < `IN_LEN; i++)
         r.smp[i] = sample_t'(tab_in[t][i]);
      return r;
   endfunction

   function automatic out_row_t tab_result(input int t);
      out_row_t o;
      for (int i = 0; i < `OUT_LEN; i++)
         o.smp[i] = out_sample_t'(tab_exp[t][i]);
      return o;
   endfunction

   // --------------------
   // Bus drivers
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         tick();
         sample_valid = 1'b0;
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      tick();
      sample_valid = 1'b0;
      reg_wr       = 1'b1;
      reg_addr     = addr;
      reg_wdata    = data;
      tick();
      reg_wr = 1'b0;
   endtask

   task automatic check_reg(input string name, input reg_addr_t addr, input int expv);
      reg_data_t rd;
      tick();
      sample_valid = 1'b0;
      reg_addr     = addr;
      @(negedge clk);
      rd = reg_rdata;
      check_val(name, expv, rd);
   endtask

   // Each strobe releases the result of the row latched at the strobe before.
   task automatic model_strobe(input out_row_t e, input string name);
      if (have_latched)
      begin
         exp_q.push_back(latched);
         name_q.push_back(latched_name);
         outs_exp++;
      end
      latched      = e;
      latched_name = name;
      have_latched = 1'b1;
   endtask

   task automatic send_row(input in_row_t r, input int gap, input out_row_t e, input string name);
      for (int i = 0; i < `IN_LEN; i++)
      begin
         tick();
         sample       = r.smp[i];
         sample_valid = 1'b1;
      end
      rows_sent++;
      model_strobe(e, name);
      idle(gap + 1);
   endtask

   // The flush strobe latches the row still on the row port.
   task automatic flush_rows(input logic en);
      reg_data_t d;
      d = '0;
      d[`CTRL_FLUSH_BIT]  = 1'b1;
      d[`CTRL_ENABLE_BIT] = en;
      if (have_latched)
         model_strobe(latched, latched_name);
      write_reg(CTRL, d);
   endtask

   task automatic drain(input string name);
      while (exp_q.size() != 0)
         tick();
      idle(8);
      check_reg({name, " rows_out"}, ROWS_OUT, outs_exp);
   endtask

   // --------------------
   // Monitors
   always @(negedge clk)
   begin
      if (strobe_banned && DUT.row_strobe === 1'b1)
         abort_run("A row strobe came while samples were disabled.");
      if (out_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
            abort_run("out_valid came with no row result pending.");
         else
         begin
            check_val(name_q.pop_front(), exp_q.pop_front(), out_row);
            outs_seen++;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
         abort_run("Timeout, the run did not finish within the cycle limit.");
   end

   initial
   begin
      in_row_t r;
      int      gap;
      rst_n        = 1'b0;
      sample       = '0;
      sample_valid = 1'b0;
      reg_wr       = 1'b0;
      reg_addr     = CTRL;
      reg_wdata    = '0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      check_reg("ctrl after reset", CTRL, 0);
      check_reg("rows_in after reset", ROWS_IN, 0);
      check_reg("rows_out after reset", ROWS_OUT, 0);
      flush_rows(1'b0);
      drain("flush before any row");

      strobe_banned = 1'b1;   // Enable is still clear.
      for (int i = 0; i < 13; i++)
      begin
         tick();
         sample       = sample_t'(take_bits(8));
         sample_valid = 1'b1;
      end
      idle(4);
      strobe_banned = 1'b0;
      check_reg("rows_in while disabled", ROWS_IN, 0);

      write_reg(CTRL, reg_data_t'(1 << `CTRL_ENABLE_BIT));
      check_reg("ctrl enabled", CTRL, 1);

      for (int t = 0; t < N_TAB; t++)
      begin
         send_row(tab_row(t), tab_gap[t], tab_result(t), $sformatf("table %0d", t));
         if (t == FLUSH_AFTER)
         begin
            flush_rows(1'b1);
            drain("held flush");
         end
      end
      check_reg("rows_in after table", ROWS_IN, rows_sent);
      check_reg("rows_out after table", ROWS_OUT, outs_seen);

      for (int n = 0; n < N_RAND; n++)
      begin
         for (int i = 0; i < `IN_LEN; i++)
            r.smp[i] = sample_t'(take_bits(8));
         gap = take_bits(3);
         send_row(r, gap, ref_row(r), $sformatf("random %0d", n));
      end
      flush_rows(1'b1);
      drain("final flush");
      check_reg("rows_in at end", ROWS_IN, rows_sent);
      check_reg("rows_out at end", ROWS_OUT, outs_seen);

      if (DUT.u_interp.u_chk.fail_cnt == 0)
      begin
         $display("TB PASSED");
         $finish;
      end
      else
         abort_run("Timing assertions on the core failed.");
   end

endmodule

`default_nettype wire

/* interp_top.f */
+incdir+.
interp_data_pkg.sv
interp_reg_pkg.sv
row_assembler.sv
row_interp.sv
interp_regs.sv
interp_top.sv
interp_chk.sv
tb_interp_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_interp_top
FILELIST  ?= interp_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  = TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation did not pass, see $(LOG)."; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
